/* src/lc4_pkg.sv */
// Shared LC4 types, opcode and ALU-operation enums, and ISA constants
package lc4_pkg;

   typedef logic [15:0] word_t;    // Data word, instruction or address
   typedef logic [2:0]  reg_sel_t; // Register index R0..R7

   // Primary opcode field, insn[15:12]
   typedef enum logic [3:0] {
      OP_NOP   = 4'b0000, // Also branch group, only NOP kept
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_t;

   // Operation selected for the execute stage
   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_XOR    = 3'd4,
      ALU_NOT    = 3'd5,
      ALU_PASS_B = 3'd6  // Immediate straight through, CONST
   } alu_op_t;

   // Sub-opcodes in insn[5:3] when insn[5] is clear
   localparam logic [2:0] ARITH_ADD = 3'b000;
   localparam logic [2:0] ARITH_SUB = 3'b010;
   localparam logic [2:0] LOGIC_AND = 3'b000;
   localparam logic [2:0] LOGIC_NOT = 3'b001;
   localparam logic [2:0] LOGIC_OR  = 3'b010;
   localparam logic [2:0] LOGIC_XOR = 3'b011;

   // Architectural register count
   localparam word_t NUM_REGS = 16'd8;

   // All-zero word, decodes as NOP and fills bubbles
   localparam word_t NOP_INSN = 16'h0000;

endpackage

/* src/fetch_unit.sv */
// Fetch stage: PC register, PC increment, fetch-to-decode registers
`timescale 1ns/1ps

module fetch_unit import lc4_pkg::*; #(
   parameter word_t RESET_PC = 16'h8200
) (
   input  logic  gwe,
   input  logic  i_rst,
   input  word_t i_insn,   // Instruction memory data for o_pc
   output word_t o_pc,     // Fetch address
   output word_t o_d_pc,   // Decode stage PC
   output word_t o_d_insn  // Decode stage instruction
);

   word_t pc;
   word_t pc_next;

   assign pc_next = pc + 16'd1; // No control flow, always sequential
   assign o_pc    = pc;

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         pc <= RESET_PC;
      end else begin
         pc <= pc_next;
      end
   end

   // F -> D pipeline registers
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         o_d_pc   <= '0;
         o_d_insn <= NOP_INSN; // Bubble
      end else begin
         o_d_pc   <= pc;
         o_d_insn <= i_insn;
      end
   end

endmodule

/* src/insn_decoder.sv */
// Combinational decoder for the kept LC4 instructions
`timescale 1ns/1ps

module insn_decoder import lc4_pkg::*; (
   input  word_t    i_insn,
   output reg_sel_t o_rs_sel,   // First source, insn[8:6]
   output reg_sel_t o_rt_sel,   // Second source or STR data register
   output reg_sel_t o_rd_sel,   // Destination, insn[11:9]
   output logic     o_reg_we,
   output logic     o_is_load,
   output logic     o_is_store,
   output logic     o_use_imm,  // Operand B from o_imm
   output alu_op_t  o_alu_op,
   output word_t    o_imm       // Sign-extended immediate
);

   opcode_t opcode;

   assign opcode   = opcode_t'(i_insn[15:12]);
   assign o_rs_sel = i_insn[8:6];
   assign o_rd_sel = i_insn[11:9];
   assign o_rt_sel = (opcode == OP_STR) ? i_insn[11:9] : i_insn[2:0]; // STR keeps data in [11:9]

   always_comb begin
      o_reg_we   = 1'b0; // Defaults, also for unsupported encodings
      o_is_load  = 1'b0;
      o_is_store = 1'b0;
      o_use_imm  = 1'b0;
      o_alu_op   = ALU_ADD;
      o_imm      = '0;
      case (opcode)
         OP_ARITH: begin
            if (i_insn[5]) begin // ADD imm5
               o_reg_we  = 1'b1;
               o_use_imm = 1'b1;
               o_imm     = {{11{i_insn[4]}}, i_insn[4:0]};
            end else if (i_insn[5:3] == ARITH_ADD) begin
               o_reg_we = 1'b1;
            end else if (i_insn[5:3] == ARITH_SUB) begin
               o_reg_we = 1'b1;
               o_alu_op = ALU_SUB;
            end // MUL, DIV fall through as no-ops
         end
         OP_LOGIC: begin
            o_alu_op = ALU_AND;
            if (i_insn[5]) begin // AND imm5
               o_reg_we  = 1'b1;
               o_use_imm = 1'b1;
               o_imm     = {{11{i_insn[4]}}, i_insn[4:0]};
            end else begin
               o_reg_we = 1'b1; // All four register forms are kept
               case (i_insn[5:3])
                  LOGIC_NOT: o_alu_op = ALU_NOT;
                  LOGIC_OR:  o_alu_op = ALU_OR;
                  LOGIC_XOR: o_alu_op = ALU_XOR;
                  default:   o_alu_op = ALU_AND;
               endcase
            end
         end
         OP_LDR: begin
            o_reg_we  = 1'b1;
            o_is_load = 1'b1;
            o_use_imm = 1'b1;
            o_imm     = {{10{i_insn[5]}}, i_insn[5:0]}; // Base plus offset6
         end
         OP_STR: begin
            o_is_store = 1'b1;
            o_use_imm  = 1'b1;
            o_imm      = {{10{i_insn[5]}}, i_insn[5:0]};
         end
         OP_CONST: begin
            o_reg_we  = 1'b1;
            o_use_imm = 1'b1;
            o_alu_op  = ALU_PASS_B;
            o_imm     = {{7{i_insn[8]}}, i_insn[8:0]};
         end
         default: ; // NOP, branches and the rest retire with nothing enabled
      endcase
   end

endmodule

/* src/reg_file.sv */
// Eight-entry register file, two reads, one write, write-through forwarding
`timescale 1ns/1ps

module reg_file import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst,
   input  reg_sel_t i_rs_sel,
   input  reg_sel_t i_rt_sel,
   input  reg_sel_t i_rd_sel,  // Write select from writeback
   input  logic     i_rd_we,
   input  word_t    i_rd_data,
   output word_t    o_rs_data,
   output word_t    o_rt_data
);

   word_t regs [NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_rd_data;
      end
   end

   // WD bypass, a same-cycle write wins over the stored value
   assign o_rs_data = (i_rd_we && (i_rd_sel == i_rs_sel)) ? i_rd_data : regs[i_rs_sel];
   assign o_rt_data = (i_rd_we && (i_rd_sel == i_rt_sel)) ? i_rd_data : regs[i_rt_sel];

endmodule

/* src/execute_stage.sv */
// Execute stage: decode-to-execute registers, operand bypass muxes and the ALU
`timescale 1ns/1ps

module execute_stage import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst,
   input  word_t    i_d_pc,
   input  word_t    i_d_insn,
   input  reg_sel_t i_rs_sel,
   input  reg_sel_t i_rt_sel,
   input  reg_sel_t i_rd_sel,
   input  logic     i_reg_we,
   input  logic     i_is_load,
   input  logic     i_is_store,
   input  logic     i_use_imm,
   input  alu_op_t  i_alu_op,
   input  word_t    i_imm,
   input  word_t    i_rs_data,      // From reg_file
   input  word_t    i_rt_data,
   input  reg_sel_t i_m_rd_sel,     // Memory stage destination
   input  logic     i_m_reg_we,
   input  word_t    i_m_result,
   input  reg_sel_t i_w_rd_sel,     // Writeback destination
   input  logic     i_w_reg_we,
   input  word_t    i_w_data,
   output word_t    o_x_pc,
   output word_t    o_x_insn,
   output word_t    o_x_result,     // ALU result, address for LDR/STR
   output word_t    o_x_store_data, // Bypassed rt value
   output reg_sel_t o_x_rt_sel,
   output reg_sel_t o_x_rd_sel,
   output logic     o_x_reg_we,
   output logic     o_x_is_load,
   output logic     o_x_is_store
);

   reg_sel_t x_rs_sel;
   logic     x_use_imm;
   alu_op_t  x_alu_op;
   word_t    x_imm;
   word_t    x_rs_data, x_rt_data;
   word_t    op_a, op_rt, op_b;

   // D -> X control, cleared on reset
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         o_x_pc       <= '0;
         o_x_insn     <= NOP_INSN;
         o_x_reg_we   <= 1'b0;
         o_x_is_load  <= 1'b0;
         o_x_is_store <= 1'b0;
      end else begin
         o_x_pc       <= i_d_pc;
         o_x_insn     <= i_d_insn;
         o_x_reg_we   <= i_reg_we;
         o_x_is_load  <= i_is_load;
         o_x_is_store <= i_is_store;
      end
   end

   // D -> X payload
   always_ff @(posedge gwe) begin
      x_rs_sel   <= i_rs_sel;
      o_x_rt_sel <= i_rt_sel;
      o_x_rd_sel <= i_rd_sel;
      x_use_imm  <= i_use_imm;
      x_alu_op   <= i_alu_op;
      x_imm      <= i_imm;
      x_rs_data  <= i_rs_data;
      x_rt_data  <= i_rt_data;
   end

   // Youngest producer first: MX, then WX, then register data
   assign op_a = (i_m_reg_we && (i_m_rd_sel == x_rs_sel)) ? i_m_result :
                 (i_w_reg_we && (i_w_rd_sel == x_rs_sel)) ? i_w_data   :
                 x_rs_data;
   assign op_rt = (i_m_reg_we && (i_m_rd_sel == o_x_rt_sel)) ? i_m_result :
                  (i_w_reg_we && (i_w_rd_sel == o_x_rt_sel)) ? i_w_data   :
                  x_rt_data;
   assign op_b = x_use_imm ? x_imm : op_rt;

   assign o_x_store_data = op_rt; // After LDR this is stale, fixed by the WM bypass

   always_comb begin
      case (x_alu_op)
         ALU_SUB:    o_x_result = op_a - op_b;
         ALU_AND:    o_x_result = op_a & op_b;
         ALU_OR:     o_x_result = op_a | op_b;
         ALU_XOR:    o_x_result = op_a ^ op_b;
         ALU_NOT:    o_x_result = ~op_a;
         ALU_PASS_B: o_x_result = op_b;
         default:    o_x_result = op_a + op_b; // ADD, also address generation
      endcase
   end

endmodule

/* src/memory_writeback.sv */
// Memory and writeback stages: pipeline registers, data memory drive, WM bypass, trace
`timescale 1ns/1ps

module memory_writeback import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst,
   input  word_t    i_dmem_rdata,   // Same-cycle read data
   input  word_t    i_x_pc,
   input  word_t    i_x_insn,
   input  word_t    i_x_result,
   input  word_t    i_x_store_data,
   input  reg_sel_t i_x_rt_sel,
   input  reg_sel_t i_x_rd_sel,
   input  logic     i_x_reg_we,
   input  logic     i_x_is_load,
   input  logic     i_x_is_store,
   output word_t    o_dmem_addr,
   output logic     o_dmem_we,
   output word_t    o_dmem_wdata,
   output reg_sel_t o_m_rd_sel,     // MX bypass source
   output logic     o_m_reg_we,
   output word_t    o_m_result,
   output reg_sel_t o_w_rd_sel,     // Register file write port, WX bypass
   output logic     o_w_reg_we,
   output word_t    o_w_data,
   output word_t    o_wb_pc,
   output word_t    o_wb_insn,
   output logic     o_wb_reg_we,
   output reg_sel_t o_wb_reg_sel,
   output word_t    o_wb_reg_data,
   output logic     o_wb_dmem_we,
   output word_t    o_wb_dmem_addr,
   output word_t    o_wb_dmem_data
);

   word_t    m_pc, m_insn, m_store_data;
   reg_sel_t m_rt_sel;
   logic     m_is_load, m_is_store;
   logic     m_mem_op;
   word_t    m_wdata;

   word_t    w_result, w_rdata, w_store_data;
   logic     w_is_load, w_is_store;

   // X -> M control
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         m_pc       <= '0;
         m_insn     <= NOP_INSN;
         o_m_reg_we <= 1'b0;
         m_is_load  <= 1'b0;
         m_is_store <= 1'b0;
      end else begin
         m_pc       <= i_x_pc;
         m_insn     <= i_x_insn;
         o_m_reg_we <= i_x_reg_we;
         m_is_load  <= i_x_is_load;
         m_is_store <= i_x_is_store;
      end
   end

   // X -> M payload
   always_ff @(posedge gwe) begin
      o_m_result   <= i_x_result;
      m_store_data <= i_x_store_data;
      m_rt_sel     <= i_x_rt_sel;
      o_m_rd_sel   <= i_x_rd_sel;
   end

   assign m_mem_op = m_is_load | m_is_store;

   // WM bypass, covers STR data right after an LDR
   assign m_wdata = (o_w_reg_we && (o_w_rd_sel == m_rt_sel)) ? o_w_data : m_store_data;

   assign o_dmem_addr  = m_mem_op ? o_m_result : '0;
   assign o_dmem_we    = m_is_store;
   assign o_dmem_wdata = m_is_store ? m_wdata : '0;

   // M -> W control
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         o_wb_pc    <= '0;
         o_wb_insn  <= NOP_INSN;
         o_w_reg_we <= 1'b0;
         w_is_load  <= 1'b0;
         w_is_store <= 1'b0;
      end else begin
         o_wb_pc    <= m_pc;
         o_wb_insn  <= m_insn;
         o_w_reg_we <= o_m_reg_we;
         w_is_load  <= m_is_load;
         w_is_store <= m_is_store;
      end
   end

   // M -> W payload
   always_ff @(posedge gwe) begin
      w_result     <= o_m_result;   // Also the memory address
      w_rdata      <= i_dmem_rdata;
      w_store_data <= m_wdata;
      o_w_rd_sel   <= o_m_rd_sel;
   end

   assign o_w_data = w_is_load ? w_rdata : w_result;

   // Retirement trace
   assign o_wb_reg_we    = o_w_reg_we;
   assign o_wb_reg_sel   = o_w_rd_sel;
   assign o_wb_reg_data  = o_w_data;
   assign o_wb_dmem_we   = w_is_store;
   assign o_wb_dmem_addr = (w_is_load || w_is_store) ? w_result : '0; // Zero for non-memory
   assign o_wb_dmem_data = w_is_load  ? w_rdata      :
                           w_is_store ? w_store_data :
                           '0;

endmodule

/* src/lc4_core.sv */
// Top level of the five-stage LC4 subset pipeline, stage instances and wiring
`timescale 1ns/1ps

module lc4_core import lc4_pkg::*; #(
   parameter word_t RESET_PC = 16'h8200 // First fetch address
) (
   input  logic     gwe,           // Global clock
   input  logic     i_rst,         // Synchronous reset, active high
   output word_t    o_imem_addr,   // Fetch address
   input  word_t    i_imem_insn,   // Instruction for o_imem_addr, same cycle
   output word_t    o_dmem_addr,   // Data address, zero when idle
   input  word_t    i_dmem_rdata,  // Data for o_dmem_addr, same cycle
   output logic     o_dmem_we,     // Store strobe
   output word_t    o_dmem_wdata,  // Store data
   output word_t    o_wb_pc,       // Retirement trace
   output word_t    o_wb_insn,
   output logic     o_wb_reg_we,
   output reg_sel_t o_wb_reg_sel,
   output word_t    o_wb_reg_data,
   output logic     o_wb_dmem_we,
   output word_t    o_wb_dmem_addr,
   output word_t    o_wb_dmem_data
);

   word_t    d_pc, d_insn;                       // Decode stage
   reg_sel_t d_rs_sel, d_rt_sel, d_rd_sel;
   logic     d_reg_we, d_is_load, d_is_store, d_use_imm;
   alu_op_t  d_alu_op;
   word_t    d_imm;
   word_t    d_rs_data, d_rt_data;

   word_t    x_pc, x_insn, x_result, x_store_data; // Execute stage
   reg_sel_t x_rt_sel, x_rd_sel;
   logic     x_reg_we, x_is_load, x_is_store;

   reg_sel_t m_rd_sel, w_rd_sel;                  // Bypass and writeback
   logic     m_reg_we, w_reg_we;
   word_t    m_result, w_data;

   fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_i (
      .gwe(gwe), .i_rst(i_rst), .i_insn(i_imem_insn),
      .o_pc(o_imem_addr), .o_d_pc(d_pc), .o_d_insn(d_insn)
   );

   insn_decoder insn_decoder_i (
      .i_insn(d_insn),
      .o_rs_sel(d_rs_sel), .o_rt_sel(d_rt_sel), .o_rd_sel(d_rd_sel),
      .o_reg_we(d_reg_we), .o_is_load(d_is_load), .o_is_store(d_is_store),
      .o_use_imm(d_use_imm), .o_alu_op(d_alu_op), .o_imm(d_imm)
   );

   reg_file reg_file_i (
      .gwe(gwe), .i_rst(i_rst),
      .i_rs_sel(d_rs_sel), .i_rt_sel(d_rt_sel),
      .i_rd_sel(w_rd_sel), .i_rd_we(w_reg_we), .i_rd_data(w_data), // Write port from W
      .o_rs_data(d_rs_data), .o_rt_data(d_rt_data)
   );

   execute_stage execute_stage_i (
      .gwe(gwe), .i_rst(i_rst),
      .i_d_pc(d_pc), .i_d_insn(d_insn),
      .i_rs_sel(d_rs_sel), .i_rt_sel(d_rt_sel), .i_rd_sel(d_rd_sel),
      .i_reg_we(d_reg_we), .i_is_load(d_is_load), .i_is_store(d_is_store),
      .i_use_imm(d_use_imm), .i_alu_op(d_alu_op), .i_imm(d_imm),
      .i_rs_data(d_rs_data), .i_rt_data(d_rt_data),
      .i_m_rd_sel(m_rd_sel), .i_m_reg_we(m_reg_we), .i_m_result(m_result), // MX bypass
      .i_w_rd_sel(w_rd_sel), .i_w_reg_we(w_reg_we), .i_w_data(w_data),     // WX bypass
      .o_x_pc(x_pc), .o_x_insn(x_insn), .o_x_result(x_result),
      .o_x_store_data(x_store_data), .o_x_rt_sel(x_rt_sel), .o_x_rd_sel(x_rd_sel),
      .o_x_reg_we(x_reg_we), .o_x_is_load(x_is_load), .o_x_is_store(x_is_store)
   );

   memory_writeback memory_writeback_i (
      .gwe(gwe), .i_rst(i_rst), .i_dmem_rdata(i_dmem_rdata),
      .i_x_pc(x_pc), .i_x_insn(x_insn), .i_x_result(x_result),
      .i_x_store_data(x_store_data), .i_x_rt_sel(x_rt_sel), .i_x_rd_sel(x_rd_sel),
      .i_x_reg_we(x_reg_we), .i_x_is_load(x_is_load), .i_x_is_store(x_is_store),
      .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
      .o_m_rd_sel(m_rd_sel), .o_m_reg_we(m_reg_we), .o_m_result(m_result),
      .o_w_rd_sel(w_rd_sel), .o_w_reg_we(w_reg_we), .o_w_data(w_data),
      .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn), .o_wb_reg_we(o_wb_reg_we),
      .o_wb_reg_sel(o_wb_reg_sel), .o_wb_reg_data(o_wb_reg_data),
      .o_wb_dmem_we(o_wb_dmem_we), .o_wb_dmem_addr(o_wb_dmem_addr),
      .o_wb_dmem_data(o_wb_dmem_data)
   );

endmodule

/* testbench/lc4_core_props.sv */
// Bound assertions on reset, bubble and memory-trace behavior of lc4_core
`timescale 1ns/1ps

module lc4_core_props import lc4_pkg::*; (
   input logic  gwe,
   input logic  i_rst,
   input logic  i_dmem_we,      // Store strobe of the core
   input logic  i_wb_reg_we,    // Trace port copies
   input word_t i_wb_insn,
   input logic  i_wb_dmem_we,
   input word_t i_wb_dmem_addr
);

   // No store strobe right out of reset
   dmem_we_after_reset: assert property (@(posedge gwe) i_rst |=> !i_dmem_we)
      else $error("Data memory write enable high in the cycle after reset");

   // Bubbles never write a register
   nop_no_reg_write: assert property (@(posedge gwe) disable iff (i_rst)
      (i_wb_insn == NOP_INSN) |-> !i_wb_reg_we)
      else $error("Retired NOP word with register write enable high");

   // Trace address is zero unless a load or store retires
   idle_dmem_addr_zero: assert property (@(posedge gwe) disable iff (i_rst)
      (!i_wb_dmem_we && i_wb_insn[15:12] != OP_LDR) |-> (i_wb_dmem_addr == 16'h0000))
      else $error("Trace data address nonzero for a non-memory instruction");

endmodule

bind lc4_core lc4_core_props lc4_core_props_i (
   .gwe(gwe),
   .i_rst(i_rst),
   .i_dmem_we(o_dmem_we),
   .i_wb_reg_we(o_wb_reg_we),
   .i_wb_insn(o_wb_insn),
   .i_wb_dmem_we(o_wb_dmem_we),
   .i_wb_dmem_addr(o_wb_dmem_addr)
);

/* testbench/tb_lc4_core.sv */
// Testbench for lc4_core with random program, memory models, ISA model and trace checks
`timescale 1ns/1ps

module tb_lc4_core import lc4_pkg::*; ();

   localparam int          PROG_LEN  = 200;
   localparam logic [31:0] SEED      = 32'h8f56_1e41;
   localparam word_t       RESET_PC  = 16'h8200;      // DUT default

   typedef struct packed {
      word_t    pc;
      word_t    insn;
      logic     reg_we;
      reg_sel_t reg_sel;
      word_t    reg_data;
      logic     dmem_we;
      word_t    dmem_addr;
      word_t    dmem_data;
   } trace_row_t;

   logic     gwe;
   logic     i_rst;
   word_t    i_imem_insn, i_dmem_rdata;
   word_t    o_imem_addr, o_dmem_addr, o_dmem_wdata;
   logic     o_dmem_we;
   word_t    o_wb_pc, o_wb_insn, o_wb_reg_data, o_wb_dmem_addr, o_wb_dmem_data;
   logic     o_wb_reg_we, o_wb_dmem_we;
   reg_sel_t o_wb_reg_sel;

   word_t       prog [PROG_LEN];     // Program words from RESET_PC on
   word_t       dmem [word_t];       // Data memory behind the DUT
   word_t       model_mem [word_t];  // Data memory of the ISA model
   trace_row_t  exp_q [$];           // Expected retirement rows
   logic [31:0] store_q [$];         // Expected stores as address and data
   logic [31:0] exp_store;

   lc4_core lc4_core_i (.*);

   initial begin
      gwe = 1'b0;
      forever #5 gwe = ~gwe;
   end

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("=== FAIL ===");
      $fatal(1, "Testbench stopped at the first failure");
   endtask

   function automatic word_t fetch_word(input word_t addr);
      int idx;
      idx = int'(addr - RESET_PC);
      if (idx < PROG_LEN)
         return prog[idx];
      return NOP_INSN; // Past the program
   endfunction

   // Random register that differs from avoid unless avoid is 8
   function automatic reg_sel_t pick_src(input int avoid);
      int r;
      if (avoid > 7)
         return reg_sel_t'($urandom_range(0, 7));
      r = $urandom_range(0, 6);
      if (r >= avoid)
         r++;
      return reg_sel_t'(r);
   endfunction

   function automatic word_t unsupported();
      word_t w;
      w = word_t'($urandom);
      case ($urandom_range(0, 5))
         0:       w[15:12] = 4'b0010;                  // CMP
         1:       w[15:12] = 4'b1010;                  // Shifts, MOD
         2:       w[15:12] = 4'b1101;                  // HICONST
         3:       w[15:12] = 4'b1111;                  // TRAP
         4:       w = {4'b0001, w[11:6], 3'b001, w[2:0]}; // MUL
         default: w = {4'b0000, 3'b111, w[8:0]};          // Branch always
      endcase
      return w;
   endfunction

   function automatic word_t gen_insn(input int avoid);
      reg_sel_t   d, s, t, b;
      logic [5:0] off;
      d   = reg_sel_t'($urandom_range(0, 5)); // R6, R7 keep small bases
      s   = pick_src(avoid);
      t   = pick_src(avoid);
      b   = reg_sel_t'($urandom_range(6, 7));
      off = 6'($urandom);
      case ($urandom_range(0, 19))
         0, 1:    return {4'b0001, d, s, 3'b000, t}; // ADD
         2:       return {4'b0001, d, s, 3'b010, t}; // SUB
         3:       return {4'b0101, d, s, 3'b000, t}; // AND
         4:       return {4'b0101, d, s, 3'b001, t}; // NOT
         5:       return {4'b0101, d, s, 3'b010, t}; // OR
         6:       return {4'b0101, d, s, 3'b011, t}; // XOR
         7, 8:    return {4'b0001, d, s, 1'b1, 5'($urandom)};
         9:       return {4'b0101, d, s, 1'b1, 5'($urandom)};
         10, 11:  return {4'b1001, d, 9'($urandom)};
         12:      return {4'b1001, b, 9'($urandom_range(16, 47))}; // New base
         13, 14:  return {4'b0110, d, b, off};
         15, 16:  return {4'b0111, t, b, off};
         17:      return {7'b0000000, 9'($urandom)}; // NOP with nzp clear
         18:      return unsupported();
         default: return {4'b0001, d, s, 1'b1, 5'd1};
      endcase
   endfunction

   task automatic build_program();
      int ld_dst;
      for (int i = 0; i < 8; i++) begin // Seed all registers first
         if (i < 6)
            prog[i] = {4'b1001, 3'(i), 9'($urandom)};
         else
            prog[i] = {4'b1001, 3'(i), 9'($urandom_range(16, 47))};
      end
      ld_dst = 8;
      for (int i = 8; i < PROG_LEN; i++) begin
         if (ld_dst < 8 && $urandom_range(0, 1) == 1)
            prog[i] = {4'b0111, 3'(ld_dst), 3'($urandom_range(6, 7)), 6'($urandom)};
         else
            prog[i] = gen_insn(ld_dst); // Load result kept out of the next sources
         ld_dst = (prog[i][15:12] == 4'b0110) ? int'(prog[i][11:9]) : 8;
      end
   endtask

   // Sequential interpreter with one row per program word
   task automatic run_model();
      word_t      regs [8];
      word_t      insn, a, b, res, addr, imm5, off6;
      trace_row_t row;
      for (int r = 0; r < 8; r++)
         regs[r] = 16'h0000;
      for (int i = 0; i < PROG_LEN; i++) begin
         insn = prog[i];
         a    = regs[insn[8:6]];
         b    = regs[insn[2:0]];
         imm5 = {{11{insn[4]}}, insn[4:0]};
         off6 = {{10{insn[5]}}, insn[5:0]};
         row          = '0;
         row.pc       = RESET_PC + word_t'(i);
         row.insn     = insn;
         row.reg_sel  = insn[11:9];
         row.reg_we   = 1'b1;
         case (insn[15:12])
            4'b0001: begin
               if (insn[5])
                  res = a + imm5;
               else if (insn[5:3] == 3'b000)
                  res = a + b;
               else if (insn[5:3] == 3'b010)
                  res = a - b;
               else
                  row.reg_we = 1'b0; // MUL, DIV
            end
            4'b0101: begin
               if (insn[5])
                  res = a & imm5;
               else begin
                  case (insn[4:3])
                     2'b00:   res = a & b;
                     2'b01:   res = ~a;
                     2'b10:   res = a | b;
                     default: res = a ^ b;
                  endcase
               end
            end
            4'b0110: begin
               addr          = a + off6;
               res           = model_mem.exists(addr) ? model_mem[addr] : 16'h0000;
               row.dmem_addr = addr;
               row.dmem_data = res;
            end
            4'b0111: begin
               addr            = a + off6;
               model_mem[addr] = regs[insn[11:9]];
               row.reg_we      = 1'b0;
               row.dmem_we     = 1'b1;
               row.dmem_addr   = addr;
               row.dmem_data   = regs[insn[11:9]];
               store_q.push_back({addr, regs[insn[11:9]]});
            end
            4'b1001: res = {{7{insn[8]}}, insn[8:0]};
            default: row.reg_we = 1'b0;
         endcase
         if (row.reg_we) begin
            regs[insn[11:9]] = res;
            row.reg_data     = res;
         end
         exp_q.push_back(row);
      end
   endtask

   // Both memories answer the address presented this cycle
   always @(posedge gwe) begin
      #1;
      i_imem_insn  = fetch_word(o_imem_addr);
      i_dmem_rdata = dmem.exists(o_dmem_addr) ? dmem[o_dmem_addr] : 16'h0000;
   end

   // Store port check followed by the write itself
   always @(negedge gwe) begin
      if (!i_rst && o_dmem_we) begin
         assert (store_q.size() > 0) else
            abort_run("The DUT wrote data memory although no store was pending");
         exp_store = store_q.pop_front();
         assert (o_dmem_addr == exp_store[31:16] && o_dmem_wdata == exp_store[15:0]) else
            abort_run($sformatf("Error at %0t: store %h <- %h, expected %h <- %h", $time,
                                o_dmem_addr, o_dmem_wdata, exp_store[31:16], exp_store[15:0]));
         dmem[o_dmem_addr] = o_dmem_wdata;
      end
   end

   task automatic check_bubble(input int k);
      assert (!o_wb_reg_we && !o_wb_dmem_we && o_wb_insn == NOP_INSN && !o_dmem_we) else
         abort_run($sformatf("Error at %0t: cycle %0d after reset is no bubble, insn %h",
                             $time, k, o_wb_insn));
   endtask

   task automatic check_row();
      trace_row_t e;
      e = exp_q.pop_front();
      assert (o_wb_pc == e.pc && o_wb_insn == e.insn) else
         abort_run($sformatf("Error at %0t: retired pc %h insn %h, expected pc %h insn %h",
                             $time, o_wb_pc, o_wb_insn, e.pc, e.insn));
      assert (o_wb_reg_we == e.reg_we) else
         abort_run($sformatf("Error at %0t: insn %h reg_we %b, expected %b",
                             $time, e.insn, o_wb_reg_we, e.reg_we));
      if (e.reg_we) begin
         assert (o_wb_reg_sel == e.reg_sel && o_wb_reg_data == e.reg_data) else
            abort_run($sformatf("Error at %0t: insn %h wrote R%0d = %h, expected R%0d = %h",
                                $time, e.insn, o_wb_reg_sel, o_wb_reg_data,
                                e.reg_sel, e.reg_data));
      end
      assert (o_wb_dmem_we == e.dmem_we && o_wb_dmem_addr == e.dmem_addr &&
              o_wb_dmem_data == e.dmem_data) else
         abort_run($sformatf("Error at %0t: insn %h memory trace %b %h %h, expected %b %h %h",
                             $time, e.insn, o_wb_dmem_we, o_wb_dmem_addr, o_wb_dmem_data,
                             e.dmem_we, e.dmem_addr, e.dmem_data));
   endtask

   initial begin
      i_rst        = 1'b1;
      i_imem_insn  = NOP_INSN;
      i_dmem_rdata = 16'h0000;
      void'($urandom(SEED));
      build_program();
      run_model();
      repeat (3) @(posedge gwe);
      #1 i_rst = 1'b0;
      for (int k = 0; k < 4; k++) begin // Pipeline still filling
         @(negedge gwe);
         check_bubble(k);
      end
      while (exp_q.size() > 0) begin // One row retires per cycle
         @(negedge gwe);
         check_row();
      end
      if (store_q.size() == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         abort_run($sformatf("Run ended with %0d expected stores never seen on the data port",
                             store_q.size()));
      end
   end

endmodule

/* files.f */
src/lc4_pkg.sv
src/fetch_unit.sv
src/insn_decoder.sv
src/reg_file.sv
src/execute_stage.sv
src/memory_writeback.sv
src/lc4_core.sv
testbench/lc4_core_props.sv
testbench/tb_lc4_core.sv

/* run.sh */
#!/bin/sh
# Build and run the lc4_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f files.f --top-module tb_lc4_core \
   -o tb_lc4_core > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/tb_lc4_core > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0
